// ==== source/slot_reel_pkg.sv ====
package slot_reel_pkg;

    // ----------------------------------------------------------
    // Reel geometry, all in display lines
    // ----------------------------------------------------------
    localparam int NUM_REELS    = 3;
    localparam int NUM_SYMBOLS  = 7;

    // 64-line symbol art drawn at 2x
    localparam int SYMBOL_PITCH = 128;
    localparam int STRIP_HEIGHT = NUM_SYMBOLS * SYMBOL_PITCH;

    // Window is 430 lines tall, centre row starts halfway down
    localparam int MIDDLE_ROW_TOP = 215;
    localparam int CENTER_OFFSET  = MIDDLE_ROW_TOP - (SYMBOL_PITCH / 2);

    // Advance per frame tick
    localparam int FAST_STEP = 24;
    localparam int SLOW_STEP = 12;

    // ----------------------------------------------------------
    // Types
    // ----------------------------------------------------------
    typedef logic [2:0] symbol_t;
    typedef logic [9:0] offset_t;
    typedef logic [2:0] lap_count_t;

    typedef enum logic [2:0] {
        IDLE,
        ALL_SPIN,
        REEL1_STOP,
        REEL2_STOP,
        REEL3_STOP
    } spin_state_t;

    // ----------------------------------------------------------
    // Strip contents and lap counts
    // ----------------------------------------------------------
    // Reel 0 runs in symbol order, the other two are shuffled
    // so that neighbouring symbols never differ by one
    localparam symbol_t REEL_STRIP [NUM_REELS][NUM_SYMBOLS] = '{
        '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6},
        '{3'd3, 3'd0, 3'd6, 3'd2, 3'd4, 3'd1, 3'd5},
        '{3'd2, 3'd5, 3'd0, 3'd3, 3'd6, 3'd1, 3'd4}
    };

    // Reel 0 is released as soon as the spin starts, so it gets
    // an extra lap to make the spin visible before it brakes
    // Reels 1 and 2 have already been spinning while the reel
    // before them ran its laps, two more are enough
    localparam lap_count_t REEL_LAPS [NUM_REELS] = '{3'd3, 3'd2, 3'd2};

endpackage

// ==== source/spin_sequencer.sv ====
`timescale 1ns/1ns

module spin_sequencer (
    input  logic                                                  clk,
    input  logic                                                  reset_n,
    input  logic                                                  vsync,
    input  logic                                                  start_spin,
    input  slot_reel_pkg::symbol_t [slot_reel_pkg::NUM_REELS-1:0] final_symbol,
    input  logic [slot_reel_pkg::NUM_REELS-1:0]                   laps_done,
    input  logic [slot_reel_pkg::NUM_REELS-1:0]                   stopped,
    output logic                                                  frame_tick,
    output logic                                                  spin_start,
    output logic [slot_reel_pkg::NUM_REELS-1:0]                   reel_release,
    output slot_reel_pkg::symbol_t [slot_reel_pkg::NUM_REELS-1:0] target_symbol,
    output logic                                                  done,
    output logic [2:0]                                            state_led
);

    logic                      vsync_prev;
    slot_reel_pkg::spin_state_t state;
    slot_reel_pkg::spin_state_t state_next;

    // ----------------------------------------------------------
    // Frame tick from vsync falling edge
    // ----------------------------------------------------------
    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            vsync_prev <= 1'b1;
            frame_tick <= 1'b0;
        end else begin
            vsync_prev <= vsync;
            frame_tick <= vsync_prev & ~vsync;
        end
    end

    // ----------------------------------------------------------
    // Spin state machine
    // ----------------------------------------------------------
    assign spin_start = frame_tick && (state == slot_reel_pkg::IDLE) && start_spin;

    always_comb begin
        state_next = state;
        done       = 1'b0;
        if (frame_tick) begin
            case (state)
                slot_reel_pkg::IDLE: begin
                    if (start_spin) begin
                        state_next = slot_reel_pkg::ALL_SPIN;
                    end
                end
                slot_reel_pkg::ALL_SPIN: begin
                    if (laps_done[0]) begin
                        state_next = slot_reel_pkg::REEL1_STOP;
                    end
                end
                slot_reel_pkg::REEL1_STOP: begin
                    if (laps_done[1]) begin
                        state_next = slot_reel_pkg::REEL2_STOP;
                    end
                end
                slot_reel_pkg::REEL2_STOP: begin
                    if (laps_done[2]) begin
                        state_next = slot_reel_pkg::REEL3_STOP;
                    end
                end
                slot_reel_pkg::REEL3_STOP: begin
                    // Reel 2 is the last to settle, the others stopped long before
                    if (&stopped) begin
                        state_next = slot_reel_pkg::IDLE;
                        done       = 1'b1;
                    end
                end
                default: state_next = slot_reel_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            state <= slot_reel_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Reels capture their stop offset on the start tick itself
    assign target_symbol = final_symbol;

    // One reel released per state, in order
    assign reel_release[0] = (state == slot_reel_pkg::ALL_SPIN);
    assign reel_release[1] = (state == slot_reel_pkg::REEL1_STOP);
    assign reel_release[2] = (state == slot_reel_pkg::REEL2_STOP);

    always_comb begin
        case (state)
            slot_reel_pkg::ALL_SPIN:   state_led = 3'b100;
            slot_reel_pkg::REEL1_STOP: state_led = 3'b101;
            slot_reel_pkg::REEL2_STOP: state_led = 3'b001;
            slot_reel_pkg::REEL3_STOP: state_led = 3'b110;
            default:                   state_led = 3'b000;
        endcase
    end

endmodule

// ==== source/reel_mechanism.sv ====
`timescale 1ns/1ns

module reel_mechanism #(
    parameter int REEL_INDEX = 0
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   frame_tick,
    input  logic                   spin_start,
    input  logic                   reel_release,
    input  slot_reel_pkg::symbol_t target_symbol,
    output slot_reel_pkg::offset_t offset,
    output logic                   laps_done,
    output logic                   stopped
);

    typedef enum logic [1:0] {
        REEL_STOPPED,
        REEL_FAST,
        REEL_BRAKE
    } reel_mode_t;

    reel_mode_t                 mode;
    slot_reel_pkg::lap_count_t  laps_left;
    slot_reel_pkg::offset_t     stop_offset;
    slot_reel_pkg::offset_t     stop_offset_calc;
    slot_reel_pkg::offset_t     fast_next;
    slot_reel_pkg::offset_t     slow_next;
    logic [2:0]                 target_pos;
    logic [10:0]                stop_raw;
    logic [10:0]                brake_dist;
    logic                       fast_wrap;
    logic                       brake_arrive;

    // Step forward along the strip, wrapping at its length
    function automatic slot_reel_pkg::offset_t advance(slot_reel_pkg::offset_t base,
                                                       int step);
        logic [10:0] sum;
        sum = 11'(base) + 11'(step);
        if (sum >= 11'(slot_reel_pkg::STRIP_HEIGHT)) begin
            sum = sum - 11'(slot_reel_pkg::STRIP_HEIGHT);
        end
        return slot_reel_pkg::offset_t'(sum);
    endfunction

    // ----------------------------------------------------------
    // Stop offset from target symbol
    // ----------------------------------------------------------
    // Inverse lookup of the target on this reel's strip
    always_comb begin
        target_pos = '0;
        for (int i = 0; i < slot_reel_pkg::NUM_SYMBOLS; i++) begin
            if (slot_reel_pkg::REEL_STRIP[REEL_INDEX][i] == target_symbol) begin
                target_pos = 3'(i);
            end
        end
    end

    // Back off so the target lands in the centre row
    assign stop_raw = 11'(target_pos) * 11'(slot_reel_pkg::SYMBOL_PITCH)
                    + 11'(slot_reel_pkg::STRIP_HEIGHT - slot_reel_pkg::CENTER_OFFSET);

    assign stop_offset_calc = (stop_raw >= 11'(slot_reel_pkg::STRIP_HEIGHT))
                            ? slot_reel_pkg::offset_t'(stop_raw
                                                       - 11'(slot_reel_pkg::STRIP_HEIGHT))
                            : slot_reel_pkg::offset_t'(stop_raw);

    always_ff @(posedge clk) begin
        if (spin_start) begin
            stop_offset <= stop_offset_calc;
        end
    end

    // ----------------------------------------------------------
    // Motion
    // ----------------------------------------------------------
    assign fast_next = advance(offset, slot_reel_pkg::FAST_STEP);
    assign slow_next = advance(offset, slot_reel_pkg::SLOW_STEP);
    assign fast_wrap = (fast_next < offset);

    // Forward distance still to go while braking
    assign brake_dist = (stop_offset >= offset)
                      ? 11'(stop_offset) - 11'(offset)
                      : 11'(stop_offset) + 11'(slot_reel_pkg::STRIP_HEIGHT) - 11'(offset);

    assign brake_arrive = (brake_dist <= 11'(slot_reel_pkg::SLOW_STEP));

    assign laps_done = frame_tick && (mode == REEL_FAST) && reel_release
                    && fast_wrap && (laps_left == '0);

    assign stopped = (mode == REEL_STOPPED);

    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            mode      <= REEL_STOPPED;
            offset    <= '0;
            laps_left <= '0;
        end else if (frame_tick) begin
            case (mode)
                REEL_STOPPED: begin
                    if (spin_start) begin
                        mode      <= REEL_FAST;
                        laps_left <= slot_reel_pkg::REEL_LAPS[REEL_INDEX];
                    end
                end
                REEL_FAST: begin
                    offset <= fast_next;
                    // Laps only count once the sequencer lets this reel go
                    if (reel_release && fast_wrap) begin
                        if (laps_left == '0) begin
                            mode <= REEL_BRAKE;
                        end else begin
                            laps_left <= laps_left - 1'b1;
                        end
                    end
                end
                REEL_BRAKE: begin
                    if (brake_arrive) begin
                        offset <= stop_offset;
                        mode   <= REEL_STOPPED;
                    end else begin
                        offset <= slow_next;
                    end
                end
                default: mode <= REEL_STOPPED;
            endcase
        end
    end

endmodule

// ==== source/reel_window_decoder.sv ====
`timescale 1ns/1ns

module reel_window_decoder (
    input  logic                                                  clk,
    input  logic                                                  reset_n,
    input  slot_reel_pkg::offset_t [slot_reel_pkg::NUM_REELS-1:0] reel_offset,
    output slot_reel_pkg::symbol_t [slot_reel_pkg::NUM_REELS-1:0] center_symbol
);

    logic [slot_reel_pkg::NUM_REELS-1:0][10:0] row_sum;
    slot_reel_pkg::offset_t [slot_reel_pkg::NUM_REELS-1:0] row_line;
    logic [slot_reel_pkg::NUM_REELS-1:0][2:0] row_pos;

    // Strip line at the top of the centre row, then its symbol slot
    always_comb begin
        for (int r = 0; r < slot_reel_pkg::NUM_REELS; r++) begin
            row_sum[r] = 11'(reel_offset[r]) + 11'(slot_reel_pkg::MIDDLE_ROW_TOP);
            if (row_sum[r] >= 11'(slot_reel_pkg::STRIP_HEIGHT)) begin
                row_line[r] = slot_reel_pkg::offset_t'(row_sum[r]
                                                       - 11'(slot_reel_pkg::STRIP_HEIGHT));
            end else begin
                row_line[r] = slot_reel_pkg::offset_t'(row_sum[r]);
            end
            row_pos[r] = 3'(row_line[r] / slot_reel_pkg::SYMBOL_PITCH);
        end
    end

    // Reset value matches offset 0
    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            for (int r = 0; r < slot_reel_pkg::NUM_REELS; r++) begin
                center_symbol[r] <= slot_reel_pkg::REEL_STRIP[r][slot_reel_pkg::MIDDLE_ROW_TOP
                                                                 / slot_reel_pkg::SYMBOL_PITCH];
            end
        end else begin
            for (int r = 0; r < slot_reel_pkg::NUM_REELS; r++) begin
                center_symbol[r] <= slot_reel_pkg::REEL_STRIP[r][row_pos[r]];
            end
        end
    end

endmodule

// ==== source/slot_reel_top.sv ====
`timescale 1ns/1ns

module slot_reel_top (
    input  logic                                                  clk,
    input  logic                                                  reset_n,
    input  logic                                                  vsync,
    input  logic                                                  start_spin,
    input  slot_reel_pkg::symbol_t [slot_reel_pkg::NUM_REELS-1:0] final_symbol,
    output slot_reel_pkg::offset_t [slot_reel_pkg::NUM_REELS-1:0] reel_offset,
    output slot_reel_pkg::symbol_t [slot_reel_pkg::NUM_REELS-1:0] center_symbol,
    output logic                                                  done,
    output logic [2:0]                                            state_led
);

    logic                                                  frame_tick;
    logic                                                  spin_start;
    logic [slot_reel_pkg::NUM_REELS-1:0]                   reel_release;
    logic [slot_reel_pkg::NUM_REELS-1:0]                   laps_done;
    logic [slot_reel_pkg::NUM_REELS-1:0]                   stopped;
    slot_reel_pkg::symbol_t [slot_reel_pkg::NUM_REELS-1:0] target_symbol;

    // ----------------------------------------------------------
    // Sequencer
    // ----------------------------------------------------------
    spin_sequencer i_sequencer (
        .clk           (clk),
        .reset_n       (reset_n),
        .vsync         (vsync),
        .start_spin    (start_spin),
        .final_symbol  (final_symbol),
        .laps_done     (laps_done),
        .stopped       (stopped),
        .frame_tick    (frame_tick),
        .spin_start    (spin_start),
        .reel_release  (reel_release),
        .target_symbol (target_symbol),
        .done          (done),
        .state_led     (state_led)
    );

    // ----------------------------------------------------------
    // One mechanism per reel
    // ----------------------------------------------------------
    for (genvar i = 0; i < slot_reel_pkg::NUM_REELS; i++) begin : g_reel
        reel_mechanism #(
            .REEL_INDEX (i)
        ) i_reel (
            .clk           (clk),
            .reset_n       (reset_n),
            .frame_tick    (frame_tick),
            .spin_start    (spin_start),
            .reel_release  (reel_release[i]),
            .target_symbol (target_symbol[i]),
            .offset        (reel_offset[i]),
            .laps_done     (laps_done[i]),
            .stopped       (stopped[i])
        );
    end

    // Centre row readout
    reel_window_decoder i_decoder (
        .clk           (clk),
        .reset_n       (reset_n),
        .reel_offset   (reel_offset),
        .center_symbol (center_symbol)
    );

endmodule

// ==== verification/slot_reel_chk.sv ====
`timescale 1ns/1ns

module slot_reel_chk (
    input logic                                                  clk,
    input logic                                                  reset_n,
    input logic                                                  vsync,
    input logic                                                  start_spin,
    input slot_reel_pkg::symbol_t [slot_reel_pkg::NUM_REELS-1:0] final_symbol,
    input slot_reel_pkg::offset_t [slot_reel_pkg::NUM_REELS-1:0] reel_offset,
    input slot_reel_pkg::symbol_t [slot_reel_pkg::NUM_REELS-1:0] center_symbol,
    input logic                                                  done,
    input logic [2:0]                                            state_led
);

    logic vsync_prev;
    logic tick;
    slot_reel_pkg::symbol_t [slot_reel_pkg::NUM_REELS-1:0] captured;

    // Legal successor of each LED code
    function automatic logic [2:0] next_led(logic [2:0] led);
        case (led)
            3'b000:  return 3'b100;
            3'b100:  return 3'b101;
            3'b101:  return 3'b001;
            3'b001:  return 3'b110;
            default: return 3'b000;
        endcase
    endfunction

    function automatic int fast_adv(int off);
        return (off + slot_reel_pkg::FAST_STEP) % slot_reel_pkg::STRIP_HEIGHT;
    endfunction

    // ----------------------------------------------------------
    // Reference frame tick and captured targets
    // ----------------------------------------------------------
    always_ff @(posedge clk, negedge reset_n) begin
        if (!reset_n) begin
            vsync_prev <= 1'b1;
            tick       <= 1'b0;
        end else begin
            vsync_prev <= vsync;
            tick       <= vsync_prev & ~vsync;
        end
    end

    always_ff @(posedge clk) begin
        if (tick && state_led == 3'b000 && start_spin) begin
            captured <= final_symbol;
        end
    end

    // ----------------------------------------------------------
    // Assertions
    // ----------------------------------------------------------
    a_reset_values: assert property (@(posedge clk)
        !reset_n |-> (!done && state_led == 3'b000 && reel_offset == '0))
        else $error("FAILED reset_values: expected done 0 led 000 offsets 0, actual %0b %03b %h",
                    done, state_led, reel_offset);

    a_offset_stable: assert property (@(posedge clk) disable iff (!reset_n)
        !tick |=> $stable(reel_offset))
        else $error("Reel offset changed without a frame tick");

    a_led_legal: assert property (@(posedge clk) disable iff (!reset_n)
        state_led inside {3'b000, 3'b100, 3'b101, 3'b001, 3'b110})
        else $error("FAILED led_legal: expected a known state code, actual %03b", state_led);

    a_led_order: assert property (@(posedge clk) disable iff (!reset_n)
        $changed(state_led) |-> state_led == next_led($past(state_led)))
        else $error("FAILED led_order: expected %03b actual %03b",
                    next_led($past(state_led)), state_led);

    a_done_single: assert property (@(posedge clk) disable iff (!reset_n)
        done |-> state_led == 3'b110 ##1 (!done && state_led == 3'b000))
        else $error("Done pulse not a single cycle ending the spin");

    a_done_on_exit: assert property (@(posedge clk) disable iff (!reset_n)
        ($past(state_led) == 3'b110 && state_led == 3'b000) |-> $past(done))
        else $error("Spin ended without a done pulse");

    for (genvar r = 0; r < slot_reel_pkg::NUM_REELS; r++) begin : g_reel_chk
        a_offset_range: assert property (@(posedge clk) disable iff (!reset_n)
            reel_offset[r] < 10'(slot_reel_pkg::STRIP_HEIGHT))
            else $error("FAILED offset_range: reel %0d expected below %0d actual %0d",
                        r, slot_reel_pkg::STRIP_HEIGHT, reel_offset[r]);

        a_fast_step: assert property (@(posedge clk) disable iff (!reset_n)
            (tick && state_led == 3'b100)
                |=> int'(reel_offset[r]) == fast_adv(int'($past(reel_offset[r]))))
            else $error("FAILED fast_step: reel %0d expected %0d actual %0d",
                        r, fast_adv(int'($past(reel_offset[r]))), reel_offset[r]);

        a_outcome: assert property (@(posedge clk) disable iff (!reset_n)
            done |=> center_symbol[r] == captured[r])
            else $error("FAILED outcome: reel %0d expected %0d actual %0d",
                        r, captured[r], center_symbol[r]);
    end

endmodule

bind slot_reel_top slot_reel_chk i_chk (
    .clk           (clk),
    .reset_n       (reset_n),
    .vsync         (vsync),
    .start_spin    (start_spin),
    .final_symbol  (final_symbol),
    .reel_offset   (reel_offset),
    .center_symbol (center_symbol),
    .done          (done),
    .state_led     (state_led)
);

// ==== verification/slot_reel_tb.sv ====
`timescale 1ns/1ns

module slot_reel_tb;

    localparam int SPIN_TIMEOUT = 40000;
    localparam int STATE_TIMEOUT = 20000;

    logic                                                  clk;
    logic                                                  reset_n;
    logic                                                  vsync;
    logic                                                  start_spin;
    slot_reel_pkg::symbol_t [slot_reel_pkg::NUM_REELS-1:0] final_symbol;
    slot_reel_pkg::offset_t [slot_reel_pkg::NUM_REELS-1:0] reel_offset;
    slot_reel_pkg::symbol_t [slot_reel_pkg::NUM_REELS-1:0] center_symbol;
    logic                                                  done;
    logic [2:0]                                            state_led;
    logic                                                  run_passed;
    logic                                                  fail_printed;
    int                                                    line_count;

    slot_reel_top i_dut (
        .clk           (clk),
        .reset_n       (reset_n),
        .vsync         (vsync),
        .start_spin    (start_spin),
        .final_symbol  (final_symbol),
        .reel_offset   (reel_offset),
        .center_symbol (center_symbol),
        .done          (done),
        .state_led     (state_led)
    );

    always #2 clk = ~clk;

    // vsync low for one cycle in twelve
    always @(posedge clk) begin
        #1;
        line_count = (line_count == 11) ? 0 : line_count + 1;
        vsync = (line_count != 0);
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    task automatic stop_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        fail_printed = 1'b1;
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped after a timeout");
    endtask

    task automatic wait_for_led(input logic [2:0] led, input string what);
        int count;
        count = 0;
        @(negedge clk);
        while (state_led != led) begin
            count++;
            if (count > STATE_TIMEOUT) begin
                stop_on_timeout(what);
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_for_done(input int spin);
        int count;
        count = 0;
        @(negedge clk);
        while (!done) begin
            count++;
            if (count > SPIN_TIMEOUT) begin
                stop_on_timeout($sformatf("done of spin %0d", spin));
            end
            @(negedge clk);
        end
        // Let the outcome check one cycle later take place
        repeat (3) @(posedge clk);
        #1;
    endtask

    task automatic pick_symbols();
        for (int r = 0; r < slot_reel_pkg::NUM_REELS; r++) begin
            final_symbol[r] = 3'($urandom % 7);
        end
    endtask

    // Request a spin, optionally disturbing the inputs mid-spin
    task automatic run_spin(input int spin, input logic change_symbols, input logic restart);
        pick_symbols();
        start_spin = 1'b1;
        wait_for_led(3'b100, "spin start");
        @(posedge clk);
        #1;
        start_spin = 1'b0;
        if (change_symbols) begin
            pick_symbols();
        end
        if (restart) begin
            wait_for_led(3'b101, "second reel release");
            @(posedge clk);
            #1;
            start_spin = 1'b1;
            repeat (40) @(posedge clk);
            #1;
            start_spin = 1'b0;
        end
        wait_for_done(spin);
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        clk          = 1'b0;
        reset_n      = 1'b0;
        vsync        = 1'b1;
        start_spin   = 1'b0;
        final_symbol = '0;
        run_passed   = 1'b0;
        fail_printed = 1'b0;
        line_count   = 0;
        void'($urandom(32'hb376));

        repeat (2) @(posedge clk);
        #1;
        reset_n = 1'b1;

        run_spin(1, 1'b0, 1'b0);
        run_spin(2, 1'b1, 1'b0);
        run_spin(3, 1'b0, 1'b1);
        run_spin(4, 1'b0, 1'b0);
        run_spin(5, 1'b0, 1'b0);

        run_passed = 1'b1;
        $display("*** PASSED ***");
        $finish;
    end

    final begin
        if (!run_passed && !fail_printed) begin
            $display("*** FAILED ***");
        end
    end

endmodule

// ==== all.f ====
source/slot_reel_pkg.sv
source/spin_sequencer.sv
source/reel_mechanism.sv
source/reel_window_decoder.sv
source/slot_reel_top.sv
verification/slot_reel_chk.sv
verification/slot_reel_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the slot reel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing \
    --top-module slot_reel_tb \
    --Mdir obj_dir \
    -o slot_reel_sim \
    -f all.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/slot_reel_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi

exit 0
